// ==== Makefile ====
# Verilator build and run for the credit link testbench
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_credit_link
FILELIST  ?= credit_link_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** TEST PASSED ***
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation passes only if the pass message shows up in the log
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== credit_cfg_regs.sv ====
// APB slave for the credit link configuration and status
// pready is tied high, every transfer ends in its access phase
// prdata is combinational and only non-zero during an access phase
// Unmapped addresses and writes to STATUS or SENT raise pslverr
// and change nothing
// Reinit is a one-cycle pulse in the cycle after the write

`timescale 1ns/100ps

module credit_cfg_regs
  import credit_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  // APB slave port
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Counter and sender status
  input  logic [VALUE_W-1:0]    value,
  input  logic [VALUE_W-1:0]    available,
  input  logic                  flit_sent,
  // Configuration outputs
  output logic                  enable,
  output logic [VALUE_W-1:0]    init_credits,
  output logic [VALUE_W-1:0]    withhold,
  output logic                  reinit
);

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------

  logic              access;
  logic              hit_ctrl;
  logic              hit_init;
  logic              hit_withhold;
  logic              hit_status;
  logic              hit_sent;
  logic              mapped;
  logic              read_only;
  logic              wr_ok;
  logic [SENT_W-1:0] sent_count;

  // Access phase of any transfer
  assign access = psel && penable;

  assign hit_ctrl     = (paddr == REG_CTRL);
  assign hit_init     = (paddr == REG_INIT);
  assign hit_withhold = (paddr == REG_WITHHOLD);
  assign hit_status   = (paddr == REG_STATUS);
  assign hit_sent     = (paddr == REG_SENT);

  assign mapped    = hit_ctrl || hit_init || hit_withhold || hit_status || hit_sent;
  assign read_only = hit_status || hit_sent;

  // Zero wait states
  assign pready  = 1'b1;
  assign pslverr = access && (!mapped || (pwrite && read_only));

  // Legal write, committed at the edge ending the access phase
  assign wr_ok = access && pwrite && mapped && !read_only;

  // --------------------------------------------------------------------------
  // Writable registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      enable       <= 1'b0;
      init_credits <= INIT_DEFAULT;
      withhold     <= '0;
      reinit       <= 1'b0;
    end else begin
      // Pulse lasts one cycle unless rewritten
      reinit <= wr_ok && hit_ctrl && pwdata[CTRL_REINIT_BIT];
      if (wr_ok && hit_ctrl) begin
        enable <= pwdata[CTRL_ENABLE_BIT];
      end
      if (wr_ok && hit_init) begin
        init_credits <= pwdata[VALUE_W-1:0];
      end
      if (wr_ok && hit_withhold) begin
        withhold <= pwdata[VALUE_W-1:0];
      end
    end
  end

  // Sent-flit counter, wraps, cleared together with the credit reload
  always_ff @(posedge clk) begin
    if (reset || reinit) begin
      sent_count <= '0;
    end else if (flit_sent) begin
      sent_count <= sent_count + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Read mux
  // --------------------------------------------------------------------------

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (hit_ctrl) begin
        // Reinit bit always reads as 0
        prdata[CTRL_ENABLE_BIT] = enable;
      end
      if (hit_init) begin
        prdata[VALUE_W-1:0] = init_credits;
      end
      if (hit_withhold) begin
        prdata[VALUE_W-1:0] = withhold;
      end
      if (hit_status) begin
        prdata[VALUE_W-1:0]   = value;
        prdata[VALUE_W+7:8]   = available;
      end
      if (hit_sent) begin
        prdata[SENT_W-1:0] = sent_count;
      end
    end
  end

endmodule : credit_cfg_regs

// ==== credit_counter.sv ====
// Sender-side credit pool for one long-distance link
// Returned credits add to the pool, a granted decrement subtracts from it
// No overflow protection: the user must never return more credits than
// were consumed, or the 4-bit value wraps
// Withhold only hides credits from available, the value keeps them

`timescale 1ns/100ps

module credit_counter
  import credit_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  // Credit return from the remote receiver
  input  logic                incr_valid,
  input  logic [CHANGE_W-1:0] incr,
  // Cost request from the sender
  input  logic                decr_valid,
  input  logic [CHANGE_W-1:0] decr,
  output logic                decr_ready,
  // Reload source and software reinit
  input  logic [VALUE_W-1:0]  init_credits,
  input  logic                reload,
  input  logic [VALUE_W-1:0]  withhold,
  // Pool state
  output logic [VALUE_W-1:0]  value,
  output logic [VALUE_W-1:0]  available
);

  // --------------------------------------------------------------------------
  // Increment path
  // --------------------------------------------------------------------------

  logic [CHANGE_W-1:0] incr_amt;
  logic [CHANGE_W-1:0] decr_amt;
  logic [VALUE_W-1:0]  value_plus_incr;
  logic [VALUE_W-1:0]  value_next;
  logic                decr_fire;

  // Return counts only when flagged valid
  assign incr_amt = incr_valid ? incr : '0;

  // Pool as seen this cycle, return already included
  assign value_plus_incr = value + VALUE_W'(incr_amt);

  // --------------------------------------------------------------------------
  // Available credit and grant
  // --------------------------------------------------------------------------

  // Floored at zero when withhold exceeds the pool
  // The decrement stays out of this sum, else decr_ready would loop back
  assign available = (value_plus_incr > withhold) ? (value_plus_incr - withhold) : '0;

  // Grant compares the raw cost, independent of decr_valid
  // so the source sees ready whether or not it offers a flit
  assign decr_ready = (VALUE_W'(decr) <= available);

  assign decr_fire = decr_valid && decr_ready;

  // Cost applied only when the grant is taken
  assign decr_amt = decr_fire ? decr : '0;

  // --------------------------------------------------------------------------
  // Pool register
  // --------------------------------------------------------------------------

  // Return and cost may land in the same cycle
  assign value_next = value_plus_incr - VALUE_W'(decr_amt);

  // Reload wins over any same-cycle return or cost
  always_ff @(posedge clk) begin
    if (reset || reload) begin
      value <= init_credits;
    end else begin
      value <= value_next;
    end
  end

endmodule : credit_counter

// ==== credit_link_chk.sv ====
// Concurrent checks on the credit link top-level ports
// Bound into every credit_link_top instance
// available is the net driven by the credit counter's output port
// All checks are off while reset is high

`timescale 1ns/100ps

module credit_link_chk
  import credit_pkg::*;
(
  input logic                clk,
  input logic                reset,
  input logic                in_valid,
  input logic                in_ready,
  input logic [CHANGE_W-1:0] in_cost,
  input logic                out_valid,
  input logic [VALUE_W-1:0]  available
);

  // --------------------------------------------------------------------------
  // Flit path
  // --------------------------------------------------------------------------

  // Each output flit comes from an acceptance on the edge before
  property out_follows_accept;
    @(posedge clk) disable iff (reset)
      out_valid |-> $past(in_valid && in_ready);
  endproperty

  // Ready never promises more credit than the pool shows
  property ready_within_credit;
    @(posedge clk) disable iff (reset)
      in_ready |-> (VALUE_W'(in_cost) <= available);
  endproperty

  a_out_follows_accept : assert property (out_follows_accept)
    else $error("out_valid high without a flit accepted on the previous edge");
  a_ready_within_credit : assert property (ready_within_credit)
    else $error("in_ready high while in_cost exceeds available credit");

endmodule : credit_link_chk

bind credit_link_top credit_link_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .in_cost   (in_cost),
  .out_valid (out_valid),
  .available (available)
);

// ==== credit_link_top.f ====
credit_pkg.sv
credit_counter.sv
credit_cfg_regs.sv
flit_sender.sv
credit_link_top.sv
credit_link_chk.sv
tb_clock_gen.sv
tb_credit_link.sv

// ==== credit_link_top.sv ====
// Top level of the credit-based flit sender
// Connects the APB register block, the credit pool and the sender
// Credit returns must never exceed the credits consumed
// No logic at this level, wiring only

`timescale 1ns/100ps

module credit_link_top
  import credit_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  // APB slave
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  // Local source
  input  logic                  in_valid,
  input  logic [DATA_W-1:0]     in_data,
  input  logic [CHANGE_W-1:0]   in_cost,
  output logic                  in_ready,
  // Credit return from the receiver
  input  logic                  credit_valid,
  input  logic [CHANGE_W-1:0]   credit_count,
  // Outgoing flits
  output logic                  out_valid,
  output logic [DATA_W-1:0]     out_data,
  output logic [CHANGE_W-1:0]   out_cost
);

  // Configuration
  logic                enable;
  logic [VALUE_W-1:0]  init_credits;
  logic [VALUE_W-1:0]  withhold;
  logic                reinit;
  // Pool state
  logic [VALUE_W-1:0]  value;
  logic [VALUE_W-1:0]  available;
  // Sender to counter
  logic                decr_valid;
  logic [CHANGE_W-1:0] decr;
  logic                decr_ready;
  logic                flit_sent;

  // --------------------------------------------------------------------------
  // Register block
  // --------------------------------------------------------------------------

  credit_cfg_regs u_regs (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .value        (value),
    .available    (available),
    .flit_sent    (flit_sent),
    .enable       (enable),
    .init_credits (init_credits),
    .withhold     (withhold),
    .reinit       (reinit)
  );

  // --------------------------------------------------------------------------
  // Credit pool and sender
  // --------------------------------------------------------------------------

  credit_counter u_counter (
    .clk          (clk),
    .reset        (reset),
    .incr_valid   (credit_valid),
    .incr         (credit_count),
    .decr_valid   (decr_valid),
    .decr         (decr),
    .decr_ready   (decr_ready),
    .init_credits (init_credits),
    .reload       (reinit),
    .withhold     (withhold),
    .value        (value),
    .available    (available)
  );

  flit_sender u_sender (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_cost    (in_cost),
    .in_ready   (in_ready),
    .decr_valid (decr_valid),
    .decr       (decr),
    .decr_ready (decr_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_cost   (out_cost),
    .flit_sent  (flit_sent)
  );

endmodule : credit_link_top

// ==== credit_pkg.sv ====
// Shared constants for the credit link: widths, limits, register map
// and reset defaults
// Credit values are 4 bits wide, so the pool never exceeds 15
// Register addresses are byte addresses on a 5-bit APB address bus

package credit_pkg;

  // --------------------------------------------------------------------------
  // Credit pool limits
  // --------------------------------------------------------------------------

  // Largest legal credit value
  localparam int MAX_CREDITS = 15;
  localparam int VALUE_W     = 4;

  // Largest cost of one flit, also largest return per cycle
  localparam int MAX_CHANGE  = 3;
  localparam int CHANGE_W    = 2;

  // Flit payload
  localparam int DATA_W      = 32;

  // --------------------------------------------------------------------------
  // APB register map
  // --------------------------------------------------------------------------

  localparam int APB_ADDR_W = 5;

  localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 5'h00;
  localparam logic [APB_ADDR_W-1:0] REG_INIT     = 5'h04;
  localparam logic [APB_ADDR_W-1:0] REG_WITHHOLD = 5'h08;
  // Read only
  localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 5'h0C;
  localparam logic [APB_ADDR_W-1:0] REG_SENT     = 5'h10;

  // Control register fields
  localparam int CTRL_ENABLE_BIT = 0;
  // Self-clearing, reads back as 0
  localparam int CTRL_REINIT_BIT = 1;

  // Reset value of the init register
  localparam logic [VALUE_W-1:0] INIT_DEFAULT = 4'd8;

  // Sent-flit counter, wraps on overflow
  localparam int SENT_W = 16;

endpackage : credit_pkg

// ==== flit_sender.sv ====
// Flit sender gated by link credit
// A flit is taken only when its cost fits in the available credit
// Output port is registered and cannot be stalled by the far side
// One flit may sit on the output while the next one is taken
// in_ready never depends on in_valid

`timescale 1ns/100ps

module flit_sender
  import credit_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  // Local source
  input  logic                in_valid,
  input  logic [DATA_W-1:0]   in_data,
  input  logic [CHANGE_W-1:0] in_cost,
  output logic                in_ready,
  // Cost request to the credit counter
  output logic                decr_valid,
  output logic [CHANGE_W-1:0] decr,
  input  logic                decr_ready,
  // Outgoing link push port
  output logic                out_valid,
  output logic [DATA_W-1:0]   out_data,
  output logic [CHANGE_W-1:0] out_cost,
  // To the sent-flit counter
  output logic                flit_sent
);

  logic accept;

  // --------------------------------------------------------------------------
  // Credit request and handshake
  // --------------------------------------------------------------------------

  // Request only while a flit is offered and the link is on
  assign decr_valid = in_valid && enable;
  // Cost is always presented, so the grant tracks it every cycle
  assign decr       = in_cost;

  assign in_ready = enable && decr_ready;
  assign accept   = in_valid && in_ready;

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------

  // Valid for exactly one cycle per accepted flit
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= accept;
    end
  end

  // Payload held between flits
  always_ff @(posedge clk) begin
    if (accept) begin
      out_data <= in_data;
      out_cost <= in_cost;
    end
  end

  // One pulse per flit on the link
  assign flit_sent = out_valid;

endmodule : flit_sender

// ==== tb_clock_gen.sv ====
// Clock and reset source for the credit link testbench
// 40 ns clock period, reset high over the first 3 rising edges
// Reset is released on a falling edge

`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // Half period of 20 ns
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Synchronous reset spans three rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule : tb_clock_gen

// ==== tb_credit_link.sv ====
// Testbench for the credit link top level
// Inputs change on the falling edge, combinational outputs are sampled 1 ns later
// The credit model assumes returns never exceed the credits consumed
// The run stops at the first mismatch

`timescale 1ns/100ps

module tb_credit_link
  import credit_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 2000;

  logic                  clk;
  logic                  reset;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  in_valid;
  logic [DATA_W-1:0]     in_data;
  logic [CHANGE_W-1:0]   in_cost;
  logic                  in_ready;
  logic                  credit_valid;
  logic [CHANGE_W-1:0]   credit_count;
  logic                  out_valid;
  logic [DATA_W-1:0]     out_data;
  logic [CHANGE_W-1:0]   out_cost;

  // Reference model state
  int model_value;
  int model_init;
  int model_withhold;
  int model_enable;
  int model_sent;
  int seed = 12967;
  int cycles = 0;

  tb_clock_gen u_clk (
    .clk   (clk),
    .reset (reset)
  );

  credit_link_top DUT (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .in_cost      (in_cost),
    .in_ready     (in_ready),
    .credit_valid (credit_valid),
    .credit_count (credit_count),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_cost     (out_cost)
  );

  // --------------------------------------------------------------------------
  // Failure handling and timeout
  // --------------------------------------------------------------------------

  task automatic stop_on_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_on_failure();
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_failure();
    end
  end

  // --------------------------------------------------------------------------
  // Credit model
  // --------------------------------------------------------------------------

  // Pool plus same-cycle return minus withhold, floored at zero
  function automatic int model_available(input int ret);
    int sum;
    sum = model_value + ret - model_withhold;
    return (sum > 0) ? sum : 0;
  endfunction

  // --------------------------------------------------------------------------
  // APB transfers, each starts and ends just after a falling edge
  // --------------------------------------------------------------------------

  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #1;
    check_eq("pslverr", 32'(pslverr), 32'h0);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    check_eq("pready", 32'(pready), 32'h1);
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // STATUS holds available in bits 11:8 and value in bits 3:0
  task automatic check_status();
    logic [31:0] rd;
    logic        err;
    apb_read(REG_STATUS, rd, err);
    check_eq("STATUS", rd, 32'(model_available(0) * 256 + model_value));
  endtask

  task automatic check_sent();
    logic [31:0] rd;
    logic        err;
    apb_read(REG_SENT, rd, err);
    check_eq("SENT", rd, 32'(model_sent));
  endtask

  // --------------------------------------------------------------------------
  // Flit and credit stimulus
  // --------------------------------------------------------------------------

  // Random payload, cost 1 to 3
  task automatic new_flit(output logic [DATA_W-1:0] data, output logic [CHANGE_W-1:0] cost);
    int pick;
    data = $random(seed);
    pick = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
    cost = CHANGE_W'(pick);
  endtask

  // Random return, never more than the credits out on the link
  task automatic pick_return(output logic [CHANGE_W-1:0] ret);
    int room;
    int amount;
    room   = model_init - model_value;
    amount = ($random(seed) & 32'h7fff_ffff) % 4;
    if (amount > room) begin
      amount = room;
    end
    ret = CHANGE_W'(amount);
  endtask

  // One clock of source offer and credit return, with model update
  // An offered flit that is not taken stays on in_valid
  task automatic run_cycle(input bit offer, input logic [DATA_W-1:0] data,
                           input logic [CHANGE_W-1:0] cost, input logic [CHANGE_W-1:0] ret,
                           output bit taken);
    int avail;
    bit exp_ready;
    in_valid     = offer;
    in_data      = data;
    in_cost      = cost;
    credit_valid = (ret != 0);
    credit_count = ret;
    #1;
    avail     = model_available(int'(ret));
    exp_ready = (model_enable != 0) && (int'(cost) <= avail);
    check_eq("in_ready", 32'(in_ready), 32'(exp_ready));
    taken       = offer && exp_ready;
    model_value = model_value + int'(ret) - (taken ? int'(cost) : 0);
    if (taken) begin
      model_sent = model_sent + 1;
    end
    @(negedge clk);
    // Registered output, one cycle after the accepting edge
    check_eq("out_valid", 32'(out_valid), 32'(taken));
    if (taken) begin
      check_eq("out_data", out_data, data);
      check_eq("out_cost", 32'(out_cost), 32'(cost));
      in_valid = 1'b0;
    end
    credit_valid = 1'b0;
    credit_count = '0;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    logic [31:0]         rd;
    logic                err;
    logic [DATA_W-1:0]   data;
    logic [CHANGE_W-1:0] cost;
    logic [CHANGE_W-1:0] ret;
    bit                  taken;
    int                  room;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    in_valid       = 1'b0;
    in_data        = '0;
    in_cost        = '0;
    credit_valid   = 1'b0;
    credit_count   = '0;
    model_value    = int'(INIT_DEFAULT);
    model_init     = int'(INIT_DEFAULT);
    model_withhold = 0;
    model_enable   = 0;
    model_sent     = 0;
    wait (reset == 1'b0);
    @(negedge clk);

    // Reset state and an unmapped address
    check_eq("out_valid", 32'(out_valid), 32'h0);
    check_eq("in_ready", 32'(in_ready), 32'h0);
    check_status();
    apb_read(REG_CTRL, rd, err);
    check_eq("CTRL", rd, 32'h0);
    apb_read(5'h14, rd, err);
    check_eq("pslverr", 32'(err), 32'h1);

    // Enable, then send until a flit no longer fits
    apb_write(REG_CTRL, 32'h1);
    model_enable = 1;
    taken = 1'b1;
    while (taken) begin
      new_flit(data, cost);
      run_cycle(1'b1, data, cost, 2'd0, taken);
    end
    check_sent();

    // Blocked flit goes in the cycle a single return makes room
    while (!taken) begin
      run_cycle(1'b1, data, cost, 2'd1, taken);
    end
    // Random returns, some landing with an accepted flit
    repeat (12) begin
      new_flit(data, cost);
      taken = 1'b0;
      while (!taken) begin
        pick_return(ret);
        run_cycle(1'b1, data, cost, ret, taken);
      end
    end
    check_status();
    check_sent();

    // Withhold of 5, refill to the full pool first
    apb_write(REG_WITHHOLD, 32'd5);
    model_withhold = 5;
    check_status();
    while (model_value < model_init) begin
      room = model_init - model_value;
      ret  = (room > 3) ? 2'd3 : CHANGE_W'(room);
      run_cycle(1'b0, '0, 2'd3, ret, taken);
    end
    check_status();
    new_flit(data, cost);
    run_cycle(1'b1, data, 2'd3, 2'd0, taken);
    // Cost 1 fits in the pool, not past the withhold
    run_cycle(1'b0, '0, 2'd1, 2'd0, taken);
    check_status();
    apb_write(REG_WITHHOLD, 32'd0);
    model_withhold = 0;
    check_status();
    new_flit(data, cost);
    run_cycle(1'b1, data, 2'd1, 2'd0, taken);

    // New init value, then reinit with enable kept on
    apb_write(REG_INIT, 32'd12);
    model_init = 12;
    apb_write(REG_CTRL, 32'h3);
    model_value = model_init;
    model_sent  = 0;
    apb_read(REG_CTRL, rd, err);
    check_eq("CTRL", rd, 32'h1);
    check_status();
    check_sent();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : tb_credit_link
